// File: Bender.yml
package:
  name: rename_stage

sources:
  - rename_pkg.sv
  - rename_map_table.sv
  - free_list.sv
  - rename_group_scan.sv
  - rename_slot.sv
  - rename_dispatch_reg.sv
  - rename_top.sv
  - target: test
    files:
      - rename_checker.sv
      - tb_rename.sv

// File: free_list.sv
`timescale 1ns/1ps
`default_nettype none

module free_list import rename_pkg::*; (
    input  wire logic                         clk,
    input  wire logic                         rst_n,
    input  wire logic                         accept,
    input  wire alloc_cnt_t                   need,
    output preg_t      [fetch_width-1:0]      head_pregs,
    output logic       [6:0]                  free_count,
    input  wire logic                         commit_free,
    input  wire preg_t                        commit_preg
);

    preg_t      queue_q [preg_count];
    preg_t      head_q;    // the queue is preg_count deep, so pointers fit a preg_t.
    preg_t      tail_q;
    logic [6:0] count_q;
    logic [6:0] pop_cnt;
    logic [6:0] push_cnt;

    assign pop_cnt  = accept ? 7'(need) : 7'd0;
    assign push_cnt = commit_free ? 7'd1 : 7'd0;

    // the registers above the architectural range start out free, in ascending order.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < preg_count; i++) begin
                queue_q[i] <= preg_t'(i + arch_regs);
            end
        end else if (commit_free) begin
            queue_q[tail_q] <= commit_preg;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            head_q  <= '0;
            tail_q  <= preg_t'(preg_count - arch_regs);
            count_q <= 7'(preg_count - arch_regs);
        end else begin
            head_q  <= head_q + preg_t'(pop_cnt);
            tail_q  <= tail_q + preg_t'(push_cnt);
            count_q <= count_q + push_cnt - pop_cnt;   // push and pops may share a cycle.
        end
    end

    // the next entries in queue order, whether or not they are all valid.
    always_comb begin
        preg_t idx;
        idx = head_q;
        for (int i = 0; i < fetch_width; i++) begin
            head_pregs[i] = queue_q[idx];
            idx           = idx + preg_t'(1);
        end
    end

    assign free_count = count_q;

endmodule

`default_nettype wire

// File: project.f
rename_pkg.sv
rename_map_table.sv
free_list.sv
rename_group_scan.sv
rename_slot.sv
rename_dispatch_reg.sv
rename_top.sv
rename_checker.sv
tb_rename.sv

// File: rename_checker.sv
`timescale 1ns/1ps
`default_nettype none

module rename_checker import rename_pkg::*; (
    input  wire logic                         clk,
    input  wire logic                         rst_n,
    input  wire logic                         in_valid,
    input  wire logic                         stall,
    input  wire logic                         out_valid,
    input  wire logic      [fetch_width-1:0]  out_op_en,
    input  wire logic      [fetch_width-1:0]  wen,
    input  wire preg_t     [fetch_width-1:0]  prd
);

    int failures = 0;

    // a held group produces nothing on the following cycle.
    assert property (@(posedge clk) disable iff (!rst_n) stall |=> !out_valid)
        else begin
            $error("out_valid rose after a stalled cycle");
            failures++;
        end

    assert property (@(posedge clk) disable iff (!rst_n) (wen & ~out_op_en) == '0)
        else begin
            $error("wen is set on a slot without out_op_en");
            failures++;
        end

    assert property (@(posedge clk) disable iff (!rst_n) stall |-> in_valid)
        else begin
            $error("stall is high without in_valid");
            failures++;
        end

    for (genvar i = 0; i < fetch_width; i++) begin : g_lane
        assert property (@(posedge clk) disable iff (!rst_n) !wen[i] |-> prd[i] == '0)
            else begin
                $error("prd of slot %0d is not zero while its wen is low", i);
                failures++;
            end
    end

endmodule

`default_nettype wire

// File: rename_dispatch_reg.sv
`timescale 1ns/1ps
`default_nettype none

module rename_dispatch_reg import rename_pkg::*; (
    input  wire logic                         clk,
    input  wire logic                         rst_n,
    input  wire logic                         accept,
    input  wire logic      [fetch_width-1:0]  op_en,
    input  wire rob_idx_t                     rob_tail,
    input  wire preg_t     [fetch_width-1:0]  prs1,
    input  wire preg_t     [fetch_width-1:0]  prs2,
    input  wire preg_t     [fetch_width-1:0]  prd,
    input  wire logic      [fetch_width-1:0]  rd_en,
    output logic                              out_valid,
    output logic           [fetch_width-1:0]  out_op_en,
    output preg_t          [fetch_width-1:0]  out_prs1,
    output preg_t          [fetch_width-1:0]  out_prs2,
    output preg_t          [fetch_width-1:0]  out_prd,
    output logic           [fetch_width-1:0]  wen,
    output rob_idx_t       [fetch_width-1:0]  rob_idx
);

    // valid and write enables only last for the cycle after an accept.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
            wen       <= '0;
            out_prd   <= '0;
        end else begin
            out_valid <= accept;
            wen       <= accept ? rd_en : '0;
            out_prd   <= accept ? prd : '0;   // keeps prd at 0 wherever wen is low.
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            out_op_en <= op_en;
            out_prs1  <= prs1;
            out_prs2  <= prs2;
            for (int i = 0; i < fetch_width; i++) begin
                rob_idx[i] <= rob_tail + rob_idx_t'(i);   // wraps with the ROB.
            end
        end
    end

endmodule

`default_nettype wire

// File: rename_group_scan.sv
`timescale 1ns/1ps
`default_nettype none

module rename_group_scan import rename_pkg::*; (
    input  wire logic      [fetch_width-1:0]  op_en,
    input  wire areg_t     [fetch_width-1:0]  rd,
    output logic           [fetch_width-1:0]  rd_en,
    output slot_idx_t      [fetch_width-1:0]  alloc_off,
    output alloc_cnt_t                        need
);

    // a slot renames only when it is live and its destination is not x0.
    always_comb begin
        for (int i = 0; i < fetch_width; i++) begin
            rd_en[i] = op_en[i] && (rd[i] != '0);
        end
    end

    // exclusive prefix count gives each slot its entry at the free list head.
    always_comb begin
        alloc_cnt_t run;
        run = '0;
        for (int i = 0; i < fetch_width; i++) begin
            alloc_off[i] = slot_idx_t'(run);
            run          = run + alloc_cnt_t'(rd_en[i]);
        end
        need = run;   // the full count is what the group asks of the free list.
    end

endmodule

`default_nettype wire

// File: rename_map_table.sv
`timescale 1ns/1ps
`default_nettype none

module rename_map_table import rename_pkg::*; (
    input  wire logic                         clk,
    input  wire logic                         rst_n,
    input  wire areg_t [fetch_width-1:0]      rd_addr1,
    input  wire areg_t [fetch_width-1:0]      rd_addr2,
    output preg_t      [fetch_width-1:0]      map_rs1,
    output preg_t      [fetch_width-1:0]      map_rs2,
    input  wire logic                         accept,
    input  wire logic  [fetch_width-1:0]      wr_en,
    input  wire areg_t [fetch_width-1:0]      wr_areg,
    input  wire preg_t [fetch_width-1:0]      wr_preg
);

    preg_t map_q [arch_regs];

    // the map is architectural state, so it comes out of reset as identity.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int r = 0; r < arch_regs; r++) begin
                map_q[r] <= preg_t'(r);
            end
        end else if (accept) begin
            // later slots overwrite earlier ones, so the youngest writer wins.
            for (int i = 0; i < fetch_width; i++) begin
                if (wr_en[i]) begin
                    map_q[wr_areg[i]] <= wr_preg[i];
                end
            end
        end
    end

    // two reads per slot; intra-group bypass is handled in the lanes.
    always_comb begin
        for (int i = 0; i < fetch_width; i++) begin
            map_rs1[i] = map_q[rd_addr1[i]];
            map_rs2[i] = map_q[rd_addr2[i]];
        end
    end

endmodule

`default_nettype wire

// File: rename_pkg.sv
`default_nettype none

package rename_pkg;

    localparam int fetch_width = 4;   // instructions offered by decode per cycle.
    localparam int arch_regs   = 32;
    localparam int preg_count  = 64;

    // architectural register number, x0 is hardwired and never renamed.
    typedef logic [$clog2(arch_regs)-1:0] areg_t;

    // physical register number.
    typedef logic [$clog2(preg_count)-1:0] preg_t;

    // position of an instruction inside a group.
    typedef logic [$clog2(fetch_width)-1:0] slot_idx_t;

    // registers a group needs, 0 up to fetch_width inclusive.
    typedef logic [$clog2(fetch_width):0] alloc_cnt_t;

    // ROB entry index.
    typedef logic [5:0] rob_idx_t;

endpackage

`default_nettype wire

// File: rename_slot.sv
`timescale 1ns/1ps
`default_nettype none

module rename_slot import rename_pkg::*; (
    input  wire slot_idx_t                    lane,
    input  wire areg_t                        rs1,
    input  wire areg_t                        rs2,
    input  wire areg_t     [fetch_width-1:0]  grp_rd,
    input  wire logic      [fetch_width-1:0]  grp_rd_en,
    input  wire preg_t                        map_rs1,
    input  wire preg_t                        map_rs2,
    input  wire preg_t     [fetch_width-1:0]  head_pregs,
    input  wire slot_idx_t                    alloc_off,
    input  wire logic                         rd_en,
    output preg_t                             prs1,
    output preg_t                             prs2,
    output preg_t                             prd
);

    assign prd = rd_en ? head_pregs[alloc_off] : '0;

    // walk the older slots in order so the nearest matching writer is the last hit.
    always_comb begin
        alloc_cnt_t off;
        preg_t      older_prd;
        off  = '0;
        prs1 = map_rs1;
        prs2 = map_rs2;
        for (int j = 0; j < fetch_width; j++) begin
            older_prd = head_pregs[slot_idx_t'(off)];   // new register of slot j.
            if (j < int'(lane) && grp_rd_en[j]) begin
                if (grp_rd[j] == rs1) begin
                    prs1 = older_prd;
                end
                if (grp_rd[j] == rs2) begin
                    prs2 = older_prd;
                end
            end
            off = off + alloc_cnt_t'(grp_rd_en[j]);
        end
        if (rs1 == '0) begin
            prs1 = '0;
        end
        if (rs2 == '0) begin
            prs2 = '0;
        end
    end

endmodule

`default_nettype wire

// File: rename_top.sv
`timescale 1ns/1ps
`default_nettype none

module rename_top import rename_pkg::*; (
    input  wire logic                         clk,
    input  wire logic                         rst_n,
    input  wire logic                         in_valid,
    input  wire logic      [fetch_width-1:0]  op_en,
    input  wire areg_t     [fetch_width-1:0]  rs1,
    input  wire areg_t     [fetch_width-1:0]  rs2,
    input  wire areg_t     [fetch_width-1:0]  rd,
    output logic                              stall,
    input  wire rob_idx_t                     rob_tail,
    input  wire logic                         commit_free,
    input  wire preg_t                        commit_preg,
    output logic                              out_valid,
    output logic           [fetch_width-1:0]  out_op_en,
    output preg_t          [fetch_width-1:0]  prs1,
    output preg_t          [fetch_width-1:0]  prs2,
    output preg_t          [fetch_width-1:0]  prd,
    output logic           [fetch_width-1:0]  wen,
    output rob_idx_t       [fetch_width-1:0]  rob_idx
);

    logic       [fetch_width-1:0] rd_en;
    slot_idx_t  [fetch_width-1:0] alloc_off;
    alloc_cnt_t                   need;
    preg_t      [fetch_width-1:0] head_pregs;
    logic       [6:0]             free_count;
    preg_t      [fetch_width-1:0] map_rs1;
    preg_t      [fetch_width-1:0] map_rs2;
    preg_t      [fetch_width-1:0] slot_prs1;
    preg_t      [fetch_width-1:0] slot_prs2;
    preg_t      [fetch_width-1:0] slot_prd;
    logic                         accept;

    // the whole group waits until the free list can cover it.
    assign stall  = in_valid && (free_count < 7'(need));
    assign accept = in_valid && !stall;

    rename_group_scan rename_group_scan_i (
        .op_en(op_en), .rd(rd), .rd_en(rd_en), .alloc_off(alloc_off), .need(need)
    );

    for (genvar g = 0; g < fetch_width; g++) begin : g_slot
        rename_slot rename_slot_i (
            .lane(slot_idx_t'(g)),
            .rs1(rs1[g]),
            .rs2(rs2[g]),
            .grp_rd(rd),
            .grp_rd_en(rd_en),
            .map_rs1(map_rs1[g]),
            .map_rs2(map_rs2[g]),
            .head_pregs(head_pregs),
            .alloc_off(alloc_off[g]),
            .rd_en(rd_en[g]),
            .prs1(slot_prs1[g]),
            .prs2(slot_prs2[g]),
            .prd(slot_prd[g])
        );
    end

    rename_map_table rename_map_table_i (
        .clk(clk), .rst_n(rst_n), .rd_addr1(rs1), .rd_addr2(rs2),
        .map_rs1(map_rs1), .map_rs2(map_rs2), .accept(accept),
        .wr_en(rd_en), .wr_areg(rd), .wr_preg(slot_prd)
    );

    free_list free_list_i (
        .clk(clk), .rst_n(rst_n), .accept(accept), .need(need),
        .head_pregs(head_pregs), .free_count(free_count),
        .commit_free(commit_free), .commit_preg(commit_preg)
    );

    rename_dispatch_reg rename_dispatch_reg_i (
        .clk(clk), .rst_n(rst_n), .accept(accept), .op_en(op_en), .rob_tail(rob_tail),
        .prs1(slot_prs1), .prs2(slot_prs2), .prd(slot_prd), .rd_en(rd_en),
        .out_valid(out_valid), .out_op_en(out_op_en), .out_prs1(prs1),
        .out_prs2(prs2), .out_prd(prd), .wen(wen), .rob_idx(rob_idx)
    );

endmodule

`default_nettype wire

// File: tb_rename.sv
`timescale 1ns/1ps
`default_nettype none

module tb_rename import rename_pkg::*; ();

    typedef areg_t [fetch_width-1:0] areg_grp_t;

    localparam int directed_groups = 4;
    localparam int random_groups   = 80;
    localparam int drain_groups    = 20;
    localparam int total_groups    = directed_groups + random_groups + drain_groups;

    logic                        clk = 1'b0;
    logic                        rst_n;
    logic                        in_valid;
    logic      [fetch_width-1:0] op_en;
    areg_grp_t                   rs1;
    areg_grp_t                   rs2;
    areg_grp_t                   rd;
    logic                        stall;
    rob_idx_t                    rob_tail;
    logic                        commit_free;
    preg_t                       commit_preg;
    logic                        out_valid;
    logic      [fetch_width-1:0] out_op_en;
    preg_t     [fetch_width-1:0] prs1;
    preg_t     [fetch_width-1:0] prs2;
    preg_t     [fetch_width-1:0] prd;
    logic      [fetch_width-1:0] wen;
    rob_idx_t  [fetch_width-1:0] rob_idx;

    preg_t                       ref_map [arch_regs];
    preg_t                       ref_free [$];    // free registers in queue order.
    preg_t                       displaced [$];   // old mappings waiting for commit.
    int unsigned                 lcg_state = 1;
    bit                          random_commits;
    bit                          exp_valid;
    logic      [fetch_width-1:0] exp_op_en;
    logic      [fetch_width-1:0] exp_wen;
    preg_t     [fetch_width-1:0] exp_prs1;
    preg_t     [fetch_width-1:0] exp_prs2;
    preg_t     [fetch_width-1:0] exp_prd;
    rob_idx_t  [fetch_width-1:0] exp_rob;

    rename_top rename_top_i (.*);

    bind rename_top rename_checker rename_checker_i (.*);

    always #5 clk = ~clk;

    function automatic int unsigned lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state >> 8;   // low bits of an LCG repeat too quickly.
    endfunction

    function automatic areg_grp_t pack_regs(input int r0, input int r1, input int r2,
                                            input int r3);
        areg_grp_t g;
        g[0] = areg_t'(r0);
        g[1] = areg_t'(r1);
        g[2] = areg_t'(r2);
        g[3] = areg_t'(r3);
        return g;
    endfunction

    // a small span gives x0 and repeated registers inside a group.
    function automatic areg_grp_t random_regs(input int span);
        areg_grp_t g;
        for (int i = 0; i < fetch_width; i++) begin
            g[i] = areg_t'(lcg_next() % span);
        end
        return g;
    endfunction

    task automatic stop_with_failure();
        $display("Simulation FAILED");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            $display("** Error at %0t: %s is %0d, expected %0d", $time, name, got, exp);
            stop_with_failure();
        end
    endtask

    function automatic preg_t expected_source(input areg_t src, input int lane);
        preg_t p;
        p = ref_map[src];
        for (int j = 0; j < lane; j++) begin
            if (exp_wen[j] && rd[j] == src) begin
                p = exp_prd[j];   // later hits are the nearer writers.
            end
        end
        if (src == '0) begin
            p = '0;
        end
        return p;
    endfunction

    task automatic predict_group();
        int taken;
        taken     = 0;
        exp_op_en = op_en;
        for (int i = 0; i < fetch_width; i++) begin
            exp_wen[i] = op_en[i] && (rd[i] != '0);
            exp_prd[i] = '0;
            if (exp_wen[i]) begin
                exp_prd[i] = ref_free[taken];
                taken++;
            end
        end
        for (int i = 0; i < fetch_width; i++) begin
            exp_prs1[i] = expected_source(rs1[i], i);
            exp_prs2[i] = expected_source(rs2[i], i);
            exp_rob[i]  = rob_idx_t'((int'(rob_tail) + i) % 64);
        end
        // writes land in slot order, so the youngest writer keeps the mapping.
        for (int i = 0; i < fetch_width; i++) begin
            if (exp_wen[i]) begin
                displaced.push_back(ref_map[rd[i]]);
                ref_map[rd[i]] = exp_prd[i];
            end
        end
        repeat (taken) void'(ref_free.pop_front());
    endtask

    task automatic compare_outputs();
        check_value("out_valid", out_valid, exp_valid);
        check_value("wen", wen, exp_valid ? exp_wen : '0);
        if (exp_valid) begin
            check_value("out_op_en", out_op_en, exp_op_en);
            for (int i = 0; i < fetch_width; i++) begin
                check_value($sformatf("prs1[%0d]", i), prs1[i], exp_prs1[i]);
                check_value($sformatf("prs2[%0d]", i), prs2[i], exp_prs2[i]);
                check_value($sformatf("prd[%0d]", i), prd[i], exp_prd[i]);
                check_value($sformatf("rob_idx[%0d]", i), rob_idx[i], exp_rob[i]);
            end
        end
    endtask

    // predicts what the coming clock edge does with the inputs now on the bus.
    task automatic step_model();
        int need;
        bit exp_stall;
        need = 0;
        for (int i = 0; i < fetch_width; i++) begin
            if (op_en[i] && rd[i] != '0) begin
                need++;
            end
        end
        exp_stall = in_valid && (need > ref_free.size());
        check_value("stall", stall, exp_stall);
        exp_valid = in_valid && !exp_stall;
        if (exp_valid) begin
            predict_group();
        end
        if (commit_free) begin
            ref_free.push_back(commit_preg);
        end
    endtask

    always @(negedge clk) begin
        if (rst_n) begin
            if (rename_top_i.rename_checker_i.failures != 0) begin
                $display("A bound assertion in rename_checker failed.");
                stop_with_failure();
            end else begin
                compare_outputs();
                step_model();
            end
        end
    end

    task automatic pick_commit(input bit allowed);
        if (allowed && displaced.size() > 0) begin
            commit_free <= 1'b1;
            commit_preg <= displaced.pop_front();
        end else begin
            commit_free <= 1'b0;
        end
    endtask

    task automatic send_group(input logic [fetch_width-1:0] en, input areg_grp_t s1,
                              input areg_grp_t s2, input areg_grp_t d);
        @(posedge clk);
        in_valid <= 1'b1;
        op_en    <= en;
        rs1      <= s1;
        rs2      <= s2;
        rd       <= d;
        rob_tail <= rob_idx_t'(lcg_next());
        pick_commit(random_commits && (lcg_next() % 2 == 0));
        @(negedge clk);
        while (stall) begin
            @(posedge clk);
            pick_commit(1'b1);   // return one register per cycle until the group fits.
            @(negedge clk);
        end
    endtask

    task automatic go_idle(input int cycles);
        @(posedge clk);
        in_valid    <= 1'b0;
        commit_free <= 1'b0;
        repeat (cycles) @(posedge clk);
    endtask

    initial begin
        repeat (total_groups * 20) @(posedge clk);
        $display("Timeout: the run did not finish within %0d cycles.", total_groups * 20);
        stop_with_failure();
    end

    initial begin
        rst_n          = 1'b0;
        in_valid       = 1'b0;
        op_en          = '0;
        rs1            = '0;
        rs2            = '0;
        rd             = '0;
        rob_tail       = '0;
        commit_free    = 1'b0;
        commit_preg    = '0;
        random_commits = 1'b0;
        exp_valid      = 1'b0;
        for (int r = 0; r < arch_regs; r++) begin
            ref_map[r] = preg_t'(r);
        end
        for (int p = arch_regs; p < preg_count; p++) begin
            ref_free.push_back(preg_t'(p));
        end
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;

        // fresh map, one x0 destination and one disabled slot.
        send_group(4'b1011, pack_regs(1, 2, 3, 4), pack_regs(5, 6, 7, 8),
                   pack_regs(9, 0, 10, 11));
        // sources forward from the nearest older writer and never from a younger one.
        send_group(4'b1111, pack_regs(13, 12, 12, 12), pack_regs(0, 9, 14, 13),
                   pack_regs(12, 13, 12, 14));
        send_group(4'b1111, pack_regs(12, 13, 14, 9), pack_regs(10, 11, 0, 12),
                   pack_regs(16, 16, 0, 17));
        send_group(4'b1111, pack_regs(16, 17, 16, 1), pack_regs(0, 0, 0, 0),
                   pack_regs(0, 0, 0, 0));

        random_commits = 1'b1;
        for (int n = 0; n < random_groups; n++) begin
            send_group(4'(lcg_next()), random_regs(8 + 24 * (n % 2)),
                       random_regs(8 + 24 * (n % 2)), random_regs(8 + 24 * (n % 2)));
        end

        // without commits the free list runs dry and a group has to wait.
        random_commits = 1'b0;
        for (int n = 0; n < drain_groups; n++) begin
            send_group(4'b1111, random_regs(32), random_regs(32), pack_regs(1, 2, 3, 4));
        end
        go_idle(4);

        if (rename_top_i.rename_checker_i.failures == 0) begin
            $display("Simulation PASSED");
            $finish;
        end else begin
            $display("%0d bound assertions failed.", rename_top_i.rename_checker_i.failures);
            stop_with_failure();
        end
    end

endmodule

`default_nettype wire
